// ==== sources.f ====
verilog/t08_pkg.sv
verilog/t08_program_counter.sv
verilog/t08_handler.sv
verilog/t08_memory_bus.sv
verilog/t08_i2c_port.sv
verilog/t08_mem_top.sv
verification/t08_handler_chk.sv
verification/t08_tb.sv

// ==== verification/t08_tb.sv ====
/*
 * directed testbench for the memory subsystem top: preload, fetch,
 * RAM loads and stores, peripheral read and write, watchdog
 */
module t08_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        nrst;
    logic [31:0] fromregister;
    logic [31:0] mem_address;
    logic [2:0]  func3;
    logic        read;
    logic        write;
    logic [31:0] toreg;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        counter_on;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic [31:0] sensor_data;
    logic [31:0] i2c_tx;

    int          seed = 32'hc85560cb;
    // reference copy of RAM contents
    logic [31:0] model [t08_pkg::RAM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] exp_toreg;
    logic [31:0] exp_tx;
    int          cycle_count = 0;
    // preload and reset, then 40 instructions at the worst RAM load, two I2C loads, x2 margin
    int          cycle_limit = t08_pkg::RAM_WORDS + 8 +
                               2 * (40 * (6 + 2 * t08_pkg::MEM_LATENCY) +
                                    2 * 2 * t08_pkg::I2C_LATENCY);

    t08_mem_top uut (
        .clk          (clk),
        .nrst         (nrst),
        .fromregister (fromregister),
        .mem_address  (mem_address),
        .func3        (func3),
        .read         (read),
        .write        (write),
        .toreg        (toreg),
        .instruction  (instruction),
        .pc           (pc),
        .counter_on   (counter_on),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .sensor_data  (sensor_data),
        .i2c_tx       (i2c_tx)
    );

    bind t08_handler t08_handler_chk chk (
        .clk        (clk),
        .nrst       (nrst),
        .readout    (readout),
        .writeout   (writeout),
        .gdone      (gdone),
        .counter_on (counter_on)
    );

    always #5 clk = ~clk;

    // watchdog, also stops at the first strobe assertion failure
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1);
        end else if (uut.u_handler.chk.errors != 0) begin
            $display("handler strobe assertion failed at %0t", $time);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    // narrow stores keep only the low field
    function automatic logic [31:0] store_format(input logic [31:0] d, input logic [2:0] f3);
        if (f3 == t08_pkg::F3_B)
            return d & 32'h0000_00ff;
        if (f3 == t08_pkg::F3_H)
            return d & 32'h0000_ffff;
        return d;
    endfunction

    function automatic logic [31:0] load_extend(input logic [31:0] w, input logic [2:0] f3);
        case (f3)
            t08_pkg::F3_B:  return 32'($signed(w[7:0]));
            t08_pkg::F3_H:  return 32'($signed(w[15:0]));
            t08_pkg::F3_BU: return 32'(w[7:0]);
            t08_pkg::F3_HU: return 32'(w[15:0]);
            default:        return w;
        endcase
    endfunction

    // aligned word in the upper half of RAM, clear of the code
    function automatic logic [31:0] ram_addr();
        logic [31:0] r;
        r = $random(seed);
        return {21'b0, 1'b1, r[7:0], 2'b00};
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // n counts cycles up to and including the pulse
    task automatic wait_pulse(output int n);
        n = 1;
        @(posedge clk);
        while (counter_on !== 1'b1) begin
            @(posedge clk);
            n = n + 1;
        end
    endtask

    task automatic preload_ram();
        logic [31:0] w;
        for (int i = 0; i < t08_pkg::RAM_WORDS; i++) begin
            w = $random(seed);
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 32'(i) << 2;
            prog_data <= w;
            model[i]  = w;
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // one instruction, from the pulse before to the pulse after
    task automatic run_instr(input logic rd, input logic wr, input logic [2:0] f3,
                             input logic [31:0] addr, input logic [31:0] data);
        int n;
        int exp_n;
        logic is_ram;
        logic is_i2c;
        is_ram = addr < t08_pkg::RAM_LIMIT;
        is_i2c = addr == t08_pkg::I2C_ADDRESS;
        read         <= rd;
        write        <= wr;
        func3        <= f3;
        mem_address  <= addr;
        fromregister <= data;
        wait_pulse(n);
        check_word(pc, exp_pc, "pc");
        check_word(instruction, model[exp_pc[10:2]], "instruction");
        if (wr && is_ram)
            model[addr[10:2]] = store_format(data, f3);
        if (wr && is_i2c)
            exp_tx = store_format(data, f3);
        if (rd && !wr && is_ram)
            exp_toreg = load_extend(model[addr[10:2]], f3);
        if (rd && !wr && is_i2c)
            exp_toreg = load_extend(sensor_data, f3);
        check_word(toreg, exp_toreg, "toreg");
        check_word(i2c_tx, exp_tx, "i2c_tx");
        if (rd && !wr && is_i2c) begin
            // access starts 4 + MEM_LATENCY cycles after the previous pulse
            exp_n = 4 + t08_pkg::MEM_LATENCY + t08_pkg::I2C_LATENCY;
            assert (n >= exp_n) else begin
                $display("CHECK FAILED at %0t: I2C load took %0d cycles, minimum %0d",
                         $time, n, exp_n);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end else begin
            exp_n = wr ? 5 + 2 * t08_pkg::MEM_LATENCY :
                    rd ? 6 + 2 * t08_pkg::MEM_LATENCY : 4 + t08_pkg::MEM_LATENCY;
            check_word(32'(n), 32'(exp_n), "instruction cycles");
        end
        exp_pc = exp_pc + t08_pkg::PC_STEP;
    endtask

    task automatic test_reset_fetch();
        int n;
        wait_pulse(n);
        // nothing fetched yet at the first pulse
        check_word(pc, 32'h0, "pc after reset");
        check_word(toreg, 32'h0, "toreg after reset");
        repeat (6)
            run_instr(1'b0, 1'b0, t08_pkg::F3_W, $random(seed), $random(seed));
    endtask

    task automatic test_word_round_trip();
        logic [31:0] a;
        logic [31:0] d;
        repeat (3) begin
            a = ram_addr();
            d = $random(seed);
            run_instr(1'b0, 1'b1, t08_pkg::F3_W, a, d);
            run_instr(1'b1, 1'b0, t08_pkg::F3_W, a, $random(seed));
            check_word(toreg, d, "LW after SW");
        end
    endtask

    task automatic test_narrow_stores();
        logic [31:0] a;
        logic [31:0] d;
        a = ram_addr();
        d = $random(seed);
        run_instr(1'b0, 1'b1, t08_pkg::F3_B, a, d);
        run_instr(1'b1, 1'b0, t08_pkg::F3_W, a, 32'h0);
        check_word(toreg, {24'h0, d[7:0]}, "LW after SB");
        a = ram_addr();
        d = $random(seed);
        run_instr(1'b0, 1'b1, t08_pkg::F3_H, a, d);
        run_instr(1'b1, 1'b0, t08_pkg::F3_W, a, 32'h0);
        check_word(toreg, {16'h0, d[15:0]}, "LW after SH");
    endtask

    // every load width on a positive and a negative word
    // bit 7 and bit 15 opposite, so the extension bit is told apart
    task automatic test_load_extension();
        logic [2:0]  codes [5];
        logic [31:0] a;
        logic [31:0] w;
        codes = '{t08_pkg::F3_B, t08_pkg::F3_H, t08_pkg::F3_W,
                  t08_pkg::F3_BU, t08_pkg::F3_HU};
        foreach (codes[i]) begin
            for (int s = 0; s < 2; s++) begin
                a = ram_addr();
                w = $random(seed);
                w[7]  = s[0];
                w[15] = ~s[0];
                w[31] = s[0];
                run_instr(1'b0, 1'b1, t08_pkg::F3_W, a, w);
                run_instr(1'b1, 1'b0, codes[i], a, 32'h0);
            end
        end
    endtask

    task automatic test_i2c_read();
        repeat (2) begin
            // sensor value held for the whole transfer
            sensor_data <= $random(seed);
            run_instr(1'b1, 1'b0, t08_pkg::F3_W, t08_pkg::I2C_ADDRESS, 32'h0);
        end
    endtask

    task automatic test_i2c_write();
        logic [31:0] d;
        d = $random(seed);
        run_instr(1'b0, 1'b1, t08_pkg::F3_W, t08_pkg::I2C_ADDRESS, d);
        check_word(i2c_tx, d, "i2c_tx after SW");
        // RAM word sharing the low address bits of the peripheral
        run_instr(1'b1, 1'b0, t08_pkg::F3_W,
                  t08_pkg::I2C_ADDRESS & (t08_pkg::RAM_LIMIT - 32'd4), 32'h0);
    endtask

    initial begin
        nrst         = 1'b0;
        read         = 1'b0;
        write        = 1'b0;
        func3        = t08_pkg::F3_W;
        mem_address  = 32'h0;
        fromregister = 32'h0;
        prog_we      = 1'b0;
        prog_addr    = 32'h0;
        prog_data    = 32'h0;
        sensor_data  = 32'h0;
        exp_pc       = 32'h0;
        exp_toreg    = 32'h0;
        exp_tx       = 32'h0;
        // bus idle in reset, preload port free
        preload_ram();
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        test_reset_fetch();
        test_word_round_trip();
        test_narrow_stores();
        test_load_extension();
        test_i2c_read();
        test_i2c_write();
        if (uut.u_handler.chk.errors != 0) begin
            $display("handler strobe assertion failed during the run");
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== verification/t08_handler_chk.sv ====
/*
 * concurrent checks on the handler strobes: exclusive access levels,
 * single-cycle counter_on, access level drop after gdone
 */
module t08_handler_chk (
    input logic clk,
    input logic nrst,
    input logic readout,
    input logic writeout,
    input logic gdone,
    input logic counter_on
);
    timeunit 1ns;
    timeprecision 1ps;

    // failures so far, watched by the testbench
    int errors = 0;

    // one access direction at a time
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(readout && writeout))
        else begin
            errors = errors + 1;
            $error("readout and writeout are high in the same cycle");
        end

    // pc advance is a single pulse
    a_pulse_width: assert property (@(posedge clk) disable iff (!nrst)
        counter_on |=> !counter_on)
        else begin
            errors = errors + 1;
            $error("counter_on stayed high for two cycles");
        end

    // level released in the cycle after gdone
    a_level_drop: assert property (@(posedge clk) disable iff (!nrst)
        gdone |=> !(readout || writeout))
        else begin
            errors = errors + 1;
            $error("access level still high one cycle after gdone");
        end

endmodule

// ==== verilog/t08_mem_top.sv ====
/*
 * memory subsystem top: handler, program counter, bus and peripheral port
 */
module t08_mem_top (
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] fromregister,
    input  logic [31:0] mem_address,
    input  logic [2:0]  func3,
    input  logic        read,
    input  logic        write,
    output logic [31:0] toreg,
    output logic [31:0] instruction,
    output logic [31:0] pc,
    output logic        counter_on,
    input  logic        prog_we,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_data,
    input  logic [31:0] sensor_data,
    output logic [31:0] i2c_tx
);

    // handler to bus
    logic [31:0] addressnew;
    logic [31:0] tomem;
    logic        readout;
    logic        writeout;
    // bus to handler
    logic [31:0] frommem;
    logic        gdone;
    // bus and port
    logic        i2c_rd;
    logic        i2c_wr;
    logic [31:0] i2c_wdata;
    logic [31:0] i2c_rdata;
    logic        done;

    t08_handler u_handler (
        .clk          (clk),
        .nrst         (nrst),
        .write        (write),
        .read         (read),
        .gdone        (gdone),
        .done         (done),
        .func3        (func3),
        .fromregister (fromregister),
        .frommem      (frommem),
        .mem_address  (mem_address),
        .counter      (pc),
        .toreg        (toreg),
        .tomem        (tomem),
        .addressnew   (addressnew),
        .instruction  (instruction),
        .writeout     (writeout),
        .readout      (readout),
        .counter_on   (counter_on)
    );

    // pc doubles as the fetch address
    t08_program_counter u_pc (
        .clk        (clk),
        .nrst       (nrst),
        .counter_on (counter_on),
        .counter    (pc)
    );

    t08_memory_bus u_bus (
        .clk        (clk),
        .nrst       (nrst),
        .readout    (readout),
        .writeout   (writeout),
        .prog_we    (prog_we),
        .addressnew (addressnew),
        .tomem      (tomem),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .i2c_rdata  (i2c_rdata),
        .frommem    (frommem),
        .i2c_wdata  (i2c_wdata),
        .gdone      (gdone),
        .i2c_rd     (i2c_rd),
        .i2c_wr     (i2c_wr)
    );

    t08_i2c_port u_i2c (
        .clk         (clk),
        .nrst        (nrst),
        .i2c_rd      (i2c_rd),
        .i2c_wr      (i2c_wr),
        .i2c_wdata   (i2c_wdata),
        .sensor_data (sensor_data),
        .i2c_rdata   (i2c_rdata),
        .i2c_tx      (i2c_tx),
        .done        (done)
    );

endmodule

// ==== verilog/t08_i2c_port.sv ====
/*
 * peripheral port model: read transfer latency with done pulse,
 * sensor sample register and transmit register
 */
module t08_i2c_port (
    input  logic        clk,
    input  logic        nrst,
    input  logic        i2c_rd,
    input  logic        i2c_wr,
    input  logic [31:0] i2c_wdata,
    input  logic [31:0] sensor_data,
    output logic [31:0] i2c_rdata,
    output logic [31:0] i2c_tx,
    output logic        done
);

    logic [t08_pkg::I2C_CNT_W-1:0] cnt;
    logic busy;
    logic last;

    // final cycle of the transfer
    assign last = busy && (cnt == t08_pkg::I2C_CNT_LAST);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done   <= 1'b0;
            i2c_tx <= '0;
        end else begin
            done <= last;
            if (i2c_rd) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
            // writes complete at once
            if (i2c_wr) begin
                i2c_tx <= i2c_wdata;
            end
        end
    end

    // sample lands together with done
    always_ff @(posedge clk) begin
        if (last) begin
            i2c_rdata <= sensor_data;
        end
    end

endmodule

// ==== verilog/t08_memory_bus.sv ====
/*
 * memory bus: address decode, word RAM with fixed latency,
 * preload write port, peripheral strobes and read data mux
 */
module t08_memory_bus (
    input  logic        clk,
    input  logic        nrst,
    input  logic        readout,
    input  logic        writeout,
    input  logic        prog_we,
    input  logic [31:0] addressnew,
    input  logic [31:0] tomem,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_data,
    input  logic [31:0] i2c_rdata,
    output logic [31:0] frommem,
    output logic [31:0] i2c_wdata,
    output logic        gdone,
    output logic        i2c_rd,
    output logic        i2c_wr
);

    logic [31:0] ram [t08_pkg::RAM_WORDS];
    logic [31:0] ram_q;
    logic [t08_pkg::RAM_AW-1:0]    ram_idx;
    logic [t08_pkg::RAM_AW-1:0]    prog_idx;
    logic [t08_pkg::MEM_CNT_W-1:0] cnt;
    logic req;
    logic req_q;
    logic busy;
    logic start;
    logic finish;
    logic hit_ram;
    logic hit_i2c;
    logic sel_ram;
    logic sel_i2c;
    logic is_wr;

    // word index, byte lanes ignored
    assign ram_idx  = addressnew[t08_pkg::RAM_AW+1:2];
    assign prog_idx = prog_addr[t08_pkg::RAM_AW+1:2];

    assign hit_ram = addressnew < t08_pkg::RAM_LIMIT;
    assign hit_i2c = addressnew == t08_pkg::I2C_ADDRESS;

    // new access on the rising edge of either level
    assign req    = readout || writeout;
    assign start  = req && !req_q && !busy;
    assign finish = busy && (cnt == t08_pkg::MEM_CNT_LAST);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            req_q   <= 1'b0;
            busy    <= 1'b0;
            cnt     <= '0;
            gdone   <= 1'b0;
            i2c_rd  <= 1'b0;
            i2c_wr  <= 1'b0;
            sel_ram <= 1'b0;
            sel_i2c <= 1'b0;
            is_wr   <= 1'b0;
        end else begin
            req_q  <= req;
            gdone  <= finish;
            // peripheral strobes go out once, at the start
            i2c_rd <= start && readout && hit_i2c;
            i2c_wr <= start && writeout && hit_i2c;
            if (start) begin
                busy    <= 1'b1;
                cnt     <= '0;
                sel_ram <= hit_ram;
                sel_i2c <= hit_i2c;
                is_wr   <= writeout;
            end else if (finish) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // RAM array and data registers
    always_ff @(posedge clk) begin
        if (finish && is_wr && sel_ram) begin
            ram[ram_idx] <= tomem;
        end else if (prog_we && !busy && !req) begin
            // preload only between accesses
            ram[prog_idx] <= prog_data;
        end
        if (finish) begin
            ram_q <= ram[ram_idx];
        end
        if (start) begin
            i2c_wdata <= tomem;
        end
    end

    // peripheral data follows the port, so a late done still returns it
    assign frommem = sel_i2c ? i2c_rdata : ram_q;

endmodule

// ==== verilog/t08_handler.sv ====
/*
 * memory handler FSM: fetch, then optional load or store per instruction,
 * store data formatting and load sign/zero extension by funct3
 */
module t08_handler (
    input  logic        clk,
    input  logic        nrst,
    input  logic        write,
    input  logic        read,
    input  logic        gdone,
    input  logic        done,
    input  logic [2:0]  func3,
    input  logic [31:0] fromregister,
    input  logic [31:0] frommem,
    input  logic [31:0] mem_address,
    input  logic [31:0] counter,
    output logic [31:0] toreg,
    output logic [31:0] tomem,
    output logic [31:0] addressnew,
    output logic [31:0] instruction,
    output logic        writeout,
    output logic        readout,
    output logic        counter_on
);

    logic [2:0]  state;
    logic [2:0]  next_state;
    logic [31:0] next_toreg;
    logic [31:0] next_tomem;
    logic [31:0] next_addressnew;
    logic [31:0] next_instruction;
    logic        next_readout;
    logic        next_writeout;
    logic        done_seen;
    logic        next_done_seen;
    logic [31:0] store_word;
    logic [31:0] load_word;
    logic        is_ram;
    logic        is_i2c;
    logic        load_ready;

    // store data, narrow stores zero-extend into a full word
    always_comb begin
        case (func3)
            t08_pkg::F3_B: store_word = {24'b0, fromregister[7:0]};
            t08_pkg::F3_H: store_word = {16'b0, fromregister[15:0]};
            default:       store_word = fromregister;
        endcase
    end

    // load data, signed forms extend from the top bit of the field
    always_comb begin
        case (func3)
            t08_pkg::F3_B:  load_word = {{24{frommem[7]}}, frommem[7:0]};
            t08_pkg::F3_H:  load_word = {{16{frommem[15]}}, frommem[15:0]};
            t08_pkg::F3_BU: load_word = {24'b0, frommem[7:0]};
            t08_pkg::F3_HU: load_word = {16'b0, frommem[15:0]};
            // LW and anything else
            default:        load_word = frommem;
        endcase
    end

    // target of the current data access
    assign is_ram = addressnew < t08_pkg::RAM_LIMIT;
    assign is_i2c = addressnew == t08_pkg::I2C_ADDRESS;
    // peripheral loads hold REGOP until the transfer is done
    assign load_ready = !is_i2c || done || done_seen;

    always_comb begin
        next_state       = state;
        next_toreg       = toreg;
        next_tomem       = tomem;
        next_addressnew  = addressnew;
        next_instruction = instruction;
        next_readout     = readout;
        next_writeout    = writeout;
        // done may arrive while still in LWAIT
        next_done_seen   = done_seen || done;

        case (state)
            t08_pkg::ST_INC: begin
                // out of reset the pulse is raised one cycle late
                if (counter_on) begin
                    next_state = t08_pkg::ST_FETCH;
                end
            end
            t08_pkg::ST_FETCH: begin
                next_addressnew = counter;
                next_readout    = 1'b1;
                next_state      = t08_pkg::ST_FWAIT;
            end
            t08_pkg::ST_FWAIT: begin
                if (gdone) begin
                    next_instruction = frommem;
                    next_readout     = 1'b0;
                    next_state       = t08_pkg::ST_LORS;
                end
            end
            t08_pkg::ST_LORS: begin
                next_done_seen = 1'b0;
                if (write) begin
                    next_addressnew = mem_address;
                    next_tomem      = store_word;
                    next_writeout   = 1'b1;
                    next_state      = t08_pkg::ST_LWAIT;
                end else if (read) begin
                    next_addressnew = mem_address;
                    next_readout    = 1'b1;
                    next_state      = t08_pkg::ST_LWAIT;
                end else begin
                    // no data access this instruction
                    next_state = t08_pkg::ST_INC;
                end
            end
            t08_pkg::ST_LWAIT: begin
                if (gdone) begin
                    next_readout  = 1'b0;
                    next_writeout = 1'b0;
                    // stores end here, loads go on to REGOP
                    next_state = writeout ? t08_pkg::ST_INC : t08_pkg::ST_REGOP;
                end
            end
            t08_pkg::ST_REGOP: begin
                if (load_ready) begin
                    // unmapped addresses read as zero
                    next_toreg = (is_ram || is_i2c) ? load_word : 32'b0;
                    next_state = t08_pkg::ST_INC;
                end
            end
            default: begin
                next_readout  = 1'b0;
                next_writeout = 1'b0;
                next_state    = t08_pkg::ST_INC;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state       <= t08_pkg::ST_INC;
            toreg       <= '0;
            tomem       <= '0;
            addressnew  <= '0;
            instruction <= '0;
            readout     <= 1'b0;
            writeout    <= 1'b0;
            counter_on  <= 1'b0;
            done_seen   <= 1'b0;
        end else begin
            state       <= next_state;
            toreg       <= next_toreg;
            tomem       <= next_tomem;
            addressnew  <= next_addressnew;
            instruction <= next_instruction;
            readout     <= next_readout;
            writeout    <= next_writeout;
            // high for the one INC cycle that advances the pc
            counter_on  <= (next_state == t08_pkg::ST_INC);
            done_seen   <= next_done_seen;
        end
    end

endmodule

// ==== verilog/t08_program_counter.sv ====
/*
 * program counter, one word step per counter_on pulse,
 * first pulse after reset leaves it at zero
 */
module t08_program_counter (
    input  logic        clk,
    input  logic        nrst,
    input  logic        counter_on,
    output logic [31:0] counter
);

    // set until the first counter_on pulse has been seen
    logic first_pulse;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            counter     <= '0;
            first_pulse <= 1'b1;
        end else if (counter_on) begin
            if (first_pulse) begin
                // first instruction fetches from address 0
                first_pulse <= 1'b0;
            end else begin
                // next sequential instruction
                counter <= counter + t08_pkg::PC_STEP;
            end
        end
    end

endmodule

// ==== verilog/t08_pkg.sv ====
/*
 * shared constants for the memory subsystem: address map, funct3 codes,
 * access latencies, RAM geometry and handler state encodings
 */
package t08_pkg;

    // address map, byte addresses
    localparam logic [31:0] I2C_ADDRESS = 32'd923923;
    localparam logic [31:0] RAM_LIMIT   = 32'd2048;

    // RAM geometry, one entry per 32-bit word
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // load/store width codes from funct3
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;

    // request to gdone, in cycles
    localparam int MEM_LATENCY = 2;
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY);
    // counter value in the last busy cycle
    localparam logic [MEM_CNT_W-1:0] MEM_CNT_LAST = MEM_CNT_W'(MEM_LATENCY - 2);

    // i2c_rd to done, in cycles
    localparam int I2C_LATENCY = 6;
    localparam int I2C_CNT_W   = $clog2(I2C_LATENCY);
    localparam logic [I2C_CNT_W-1:0] I2C_CNT_LAST = I2C_CNT_W'(I2C_LATENCY - 2);

    // pc advance per instruction
    localparam logic [31:0] PC_STEP = 32'd4;

    // handler FSM encodings
    localparam logic [2:0] ST_INC   = 3'd0;
    localparam logic [2:0] ST_FETCH = 3'd1;
    localparam logic [2:0] ST_FWAIT = 3'd2;
    localparam logic [2:0] ST_LORS  = 3'd3;
    localparam logic [2:0] ST_LWAIT = 3'd4;
    localparam logic [2:0] ST_REGOP = 3'd5;

endpackage
